// ==== verif/matmul_input.txt ====
// per test: mode word (bits 1:0 act mode, bit 4 keeps b), four a rows,
// four b columns, four expected result rows; hex, element 0 in the low bits.
// test 0, act_none, wrapped sums with negatives
00000000
04030201
fcfdfeff
02fb000a
01007f80
00000001
00000100
01010101
04fd02ff
000a000a00020001
fff6fff6fffeffff
000d00070000000a
01820000007fff80
// test 1, act_relu, mixed-sign sums
00000001
01010101
fe02ff01
000000ff
04fd0102
00006464
00009c9c
ff01ff01
03020000
00050000000000c8
0000000600000000
0000000000640000
000600000000012c
// test 2, act_clamp, new a only, b held from test 1 (repeated for reference)
00000012
00000102
000000ff
00007f7f
140a0000
00006464
00009c9c
ff01ff01
03020000
00000001ff80007f
0000ffff0064ff9c
00000000ff80007f
0050fff600000000

// ==== list.f ====
hdl/accel_pkg.sv
hdl/op_if.sv
hdl/matrix_ram.sv
hdl/operand_feeder.sv
hdl/dot_lane.sv
hdl/result_writer.sv
hdl/matmul_accel.sv
verif/tb_matmul_accel.sv

// ==== Bender.yml ====
package:
  name: matmul_accel

sources:
  - hdl/accel_pkg.sv
  - hdl/op_if.sv
  - hdl/matrix_ram.sv
  - hdl/operand_feeder.sv
  - hdl/dot_lane.sv
  - hdl/result_writer.sv
  - hdl/matmul_accel.sv
  - target: test
    files:
      - verif/tb_matmul_accel.sv

// ==== verif/tb_matmul_accel.sv ====
module tb_matmul_accel;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tests    = 3;
  localparam int test_words = 13;                // mode, a rows, b columns, expected rows.
  localparam int max_cycles = n_tests * 60 + 5;  // 60 per test plus reset.

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 start_req;
  accel_pkg::act_mode_t mode;
  logic                 load_en;
  logic                 load_sel;
  accel_pkg::idx_t      load_addr;
  accel_pkg::row_t      load_data;
  accel_pkg::idx_t      read_addr;
  logic                 start_ack;
  accel_pkg::out_word_t read_data;

  logic [63:0] stim [n_tests*test_words];
  int cycles    = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  int test_errs = 0;

  matmul_accel u_matmul_accel (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_req (start_req),
    .mode      (mode),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .load_addr (load_addr),
    .load_data (load_data),
    .read_addr (read_addr),
    .start_ack (start_ack),
    .read_data (read_data)
  );

  always #10 clk = ~clk;  // 20 ns period.

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run stopped after %0d cycles, the accelerator never finished", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // ==========================================================================
  // checks and host actions
  // ==========================================================================
  task automatic check_word(input accel_pkg::out_word_t exp, input string what);
    if (read_data !== exp) begin
      $display("Fail at %0d ns: %s read %h, expected %h", $time, what, read_data, exp);
      test_errs++;
    end
  endtask

  task automatic check_ack(input logic exp, input string what);
    if (start_ack !== exp) begin
      $display("Fail at %0d ns: start_ack is %b %s, expected %b", $time, start_ack, what, exp);
      test_errs++;
    end
  endtask

  task automatic load_word(input logic sel, input int addr, input logic [63:0] data);
    @(negedge clk);
    load_en   = 1'b1;
    load_sel  = sel;
    load_addr = accel_pkg::idx_t'(addr);
    load_data = accel_pkg::row_t'(data);
  endtask

  task automatic run_test(input int t);
    int          base;
    logic [63:0] cfg;
    base = t * test_words;
    cfg  = stim[base];
    @(negedge clk);
    mode = accel_pkg::act_mode_t'(cfg[1:0]);
    for (int i = 0; i < accel_pkg::dim; i++) begin
      load_word(1'b0, i, stim[base+1+i]);
    end
    if (!cfg[4]) begin  // bit 4 keeps the b matrix from the last run.
      for (int i = 0; i < accel_pkg::dim; i++) begin
        load_word(1'b1, i, stim[base+5+i]);
      end
    end
    @(negedge clk);
    load_en = 1'b0;
    check_ack(1'b0, "after operand loads");
    start_req = 1'b1;
    while (start_ack !== 1'b1) begin
      @(negedge clk);
    end
    start_req = 1'b0;
    @(negedge clk);
    check_ack(1'b0, "one edge after start_req fell");
    for (int r = 0; r < accel_pkg::dim; r++) begin
      read_addr = accel_pkg::idx_t'(r);
      @(negedge clk);
      check_word(accel_pkg::out_word_t'(stim[base+9+r]), $sformatf("row %0d", r));
    end
    if (test_errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("test %0d, %s, %0d mismatches", t, mode.name(), test_errs);
    test_errs = 0;
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst_n     = 1'b0;
    start_req = 1'b0;
    mode      = accel_pkg::act_none;
    load_en   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;
    read_addr = '0;
    $readmemh("verif/matmul_input.txt", stim);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_ack(1'b0, "after reset");  // counted with the first test.
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("pass count %0d, fail count %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== hdl/matmul_accel.sv ====
module matmul_accel (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_req,
  input  accel_pkg::act_mode_t mode,
  input  logic                 load_en,
  input  logic                 load_sel,   // 0 selects a, 1 selects b.
  input  accel_pkg::idx_t      load_addr,
  input  accel_pkg::row_t      load_data,
  input  accel_pkg::idx_t      read_addr,
  output logic                 start_ack,
  output accel_pkg::out_word_t read_data
);

  // ==========================================================================
  // wires
  // ==========================================================================
  logic                 wr_en_a;
  logic                 wr_en_b;

  accel_pkg::idx_t      a_raddr;
  accel_pkg::row_t      a_rdata;
  accel_pkg::idx_t      b_raddr;
  accel_pkg::row_t      b_rdata;

  logic                 lane_valid [accel_pkg::dim];
  accel_pkg::idx_t      lane_row   [accel_pkg::dim];
  accel_pkg::acc_t      lane_sum   [accel_pkg::dim];

  logic                 c_wr_en;
  accel_pkg::idx_t      c_wr_addr;
  accel_pkg::out_word_t c_wr_data;
  logic                 frame_done;

  op_if op_bus ();

  // host load steers to one operand memory.
  assign wr_en_a = load_en & ~load_sel;
  assign wr_en_b = load_en & load_sel;

  // ==========================================================================
  // operand and result memories
  // ==========================================================================
  matrix_ram #(.word_t(accel_pkg::row_t)) u_ram_a (
    .clk     (clk),
    .wr_en   (wr_en_a),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_addr (a_raddr),
    .rd_data (a_rdata)
  );

  matrix_ram #(.word_t(accel_pkg::row_t)) u_ram_b (
    .clk     (clk),
    .wr_en   (wr_en_b),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_addr (b_raddr),
    .rd_data (b_rdata)
  );

  matrix_ram #(.word_t(accel_pkg::out_word_t)) u_ram_c (
    .clk     (clk),
    .wr_en   (c_wr_en),
    .wr_addr (c_wr_addr),
    .wr_data (c_wr_data),
    .rd_addr (read_addr),   // host readback.
    .rd_data (read_data)
  );

  // ==========================================================================
  // datapath
  // ==========================================================================
  operand_feeder u_feeder (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_req  (start_req),
    .frame_done (frame_done),
    .a_rdata    (a_rdata),
    .b_rdata    (b_rdata),
    .start_ack  (start_ack),
    .a_raddr    (a_raddr),
    .b_raddr    (b_raddr),
    .op         (op_bus.src)
  );

  for (genvar i = 0; i < accel_pkg::dim; i++) begin : g_lane
    dot_lane #(.lane_id(i)) u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .op        (op_bus.dst),
      .res_valid (lane_valid[i]),
      .res_row   (lane_row[i]),
      .res_sum   (lane_sum[i])
    );
  end

  result_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .mode       (mode),
    .res_valid  (lane_valid),
    .res_row    (lane_row),
    .res_sum    (lane_sum),
    .c_wr_en    (c_wr_en),
    .c_wr_addr  (c_wr_addr),
    .c_wr_data  (c_wr_data),
    .frame_done (frame_done)
  );

endmodule

// ==== hdl/result_writer.sv ====
module result_writer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  accel_pkg::act_mode_t mode,
  input  logic                 res_valid [accel_pkg::dim],
  input  accel_pkg::idx_t      res_row   [accel_pkg::dim],
  input  accel_pkg::acc_t      res_sum   [accel_pkg::dim],
  output logic                 c_wr_en,
  output accel_pkg::idx_t      c_wr_addr,
  output accel_pkg::out_word_t c_wr_data,
  output logic                 frame_done
);

  localparam int rw = accel_pkg::res_w;

  logic                 all_valid;
  accel_pkg::out_word_t row_word;
  accel_pkg::idx_t      wr_cnt;  // rows written this frame.

  // ==========================================================================
  // activation
  // ==========================================================================
  function automatic accel_pkg::res_t activate(
    input accel_pkg::act_mode_t m,
    input accel_pkg::acc_t      s
  );
    accel_pkg::res_t r;
    case (m)
      accel_pkg::act_relu: begin
        r = (s < 0) ? '0 : s[rw-1:0];
      end
      accel_pkg::act_clamp: begin
        if (s > accel_pkg::clamp_max) begin
          r = accel_pkg::res_t'(accel_pkg::clamp_max);
        end else if (s < accel_pkg::clamp_min) begin
          r = accel_pkg::res_t'(accel_pkg::clamp_min);  // sign-extended.
        end else begin
          r = s[rw-1:0];
        end
      end
      default: begin
        r = s[rw-1:0];  // plain wrap to 16 bits.
      end
    endcase
    return r;
  endfunction

  // lanes run in lockstep, so all four land together.
  always_comb begin
    all_valid = 1'b1;
    row_word  = '0;
    for (int j = 0; j < accel_pkg::dim; j++) begin
      all_valid = all_valid & res_valid[j];
      row_word[j*rw +: rw] = activate(mode, res_sum[j]);
    end
  end

  // ==========================================================================
  // write-back and frame count
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c_wr_en    <= 1'b0;
      frame_done <= 1'b0;
      wr_cnt     <= '0;
    end else begin
      c_wr_en    <= all_valid;
      frame_done <= 1'b0;
      if (c_wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == accel_pkg::idx_t'(accel_pkg::dim - 1)) begin
          frame_done <= 1'b1;  // last row just written.
          wr_cnt     <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (all_valid) begin
      c_wr_addr <= res_row[0];
      c_wr_data <= row_word;
    end
  end

endmodule

// ==== hdl/dot_lane.sv ====
module dot_lane #(
  parameter int lane_id = 0
) (
  input  logic            clk,
  input  logic            rst_n,
  op_if.dst               op,
  output logic            res_valid,
  output accel_pkg::idx_t res_row,
  output accel_pkg::acc_t res_sum
);

  localparam int ew = accel_pkg::elem_w;

  accel_pkg::row_t col_q;   // this lane's b column.
  accel_pkg::acc_t dot;
  logic            col_hit;
  logic            row_beat;

  assign col_hit  = op.op_valid && op.op_load_col &&
                    (op.op_index == accel_pkg::idx_t'(lane_id));
  assign row_beat = op.op_valid && !op.op_load_col;

  always_ff @(posedge clk) begin
    if (col_hit) begin
      col_q <= op.op_data;
    end
  end

  // four signed products summed at full width.
  always_comb begin
    dot = '0;
    for (int k = 0; k < accel_pkg::dim; k++) begin
      dot = dot + $signed(op.op_data[k*ew +: ew]) * $signed(col_q[k*ew +: ew]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= row_beat;  // one result per row beat.
    end
  end

  always_ff @(posedge clk) begin
    if (row_beat) begin
      res_sum <= dot;
      res_row <= op.op_index;
    end
  end

endmodule

// ==== hdl/operand_feeder.sv ====
module operand_feeder (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_req,
  input  logic            frame_done,
  input  accel_pkg::row_t a_rdata,
  input  accel_pkg::row_t b_rdata,
  output logic            start_ack,
  output accel_pkg::idx_t a_raddr,
  output accel_pkg::idx_t b_raddr,
  op_if.src               op
);

  typedef enum logic [2:0] {
    st_idle,  // waiting for start_req.
    st_col,   // reading b columns.
    st_row,   // reading a rows.
    st_wait,  // rows in flight through lanes and writer.
    st_ack    // ack high until start_req falls.
  } state_t;

  state_t          state;
  accel_pkg::idx_t rd_cnt;
  logic            last_addr;

  // read stage mirror, lines up with the ram output.
  logic            rd_valid_q;
  logic            rd_col_q;
  accel_pkg::idx_t rd_idx_q;

  assign last_addr = (rd_cnt == accel_pkg::idx_t'(accel_pkg::dim - 1));

  // both memories share the sequence counter.
  assign a_raddr = rd_cnt;
  assign b_raddr = rd_cnt;

  // ==========================================================================
  // sequencer and start handshake
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      rd_cnt    <= '0;
      start_ack <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start_req) begin
            state  <= st_col;
            rd_cnt <= '0;
          end
        end
        st_col: begin
          rd_cnt <= rd_cnt + 1'b1;  // wraps to 0 for the row phase.
          if (last_addr) begin
            state <= st_row;
          end
        end
        st_row: begin
          rd_cnt <= rd_cnt + 1'b1;
          if (last_addr) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (frame_done) begin
            state     <= st_ack;
            start_ack <= 1'b1;
          end
        end
        st_ack: begin
          if (!start_req) begin  // four-phase return to zero.
            state     <= st_idle;
            start_ack <= 1'b0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ==========================================================================
  // operand beat, one cycle behind the read
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
      rd_col_q   <= 1'b0;
    end else begin
      rd_valid_q <= (state == st_col) || (state == st_row);
      rd_col_q   <= (state == st_col);
    end
  end

  always_ff @(posedge clk) begin
    rd_idx_q <= rd_cnt;  // index delayed to match ram latency.
  end

  assign op.op_valid    = rd_valid_q;
  assign op.op_load_col = rd_col_q;
  assign op.op_index    = rd_idx_q;
  assign op.op_data     = rd_col_q ? b_rdata : a_rdata;

endmodule

// ==== hdl/matrix_ram.sv ====
// simple dual-port memory with a registered read port.
// same block holds operand rows and packed result rows.
module matrix_ram #(
  parameter type word_t = accel_pkg::row_t
) (
  input  logic            clk,
  input  logic            wr_en,
  input  accel_pkg::idx_t wr_addr,
  input  word_t           wr_data,
  input  accel_pkg::idx_t rd_addr,
  output word_t           rd_data
);

  word_t mem [accel_pkg::ram_depth];

  // write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, one cycle latency.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];  // old data on a same-address write.
  end

endmodule

// ==== hdl/op_if.sv ====
// operand broadcast from the feeder to the dot-product lanes.
// one beat per cycle, never stalled.
interface op_if;

  logic            op_valid;     // beat present this cycle.
  logic            op_load_col;  // b column beat, else a row beat.
  accel_pkg::idx_t op_index;     // column or row number.
  accel_pkg::row_t op_data;      // four packed int8 elements.

  modport src (
    output op_valid,
    output op_load_col,
    output op_index,
    output op_data
  );

  modport dst (
    input op_valid,
    input op_load_col,
    input op_index,
    input op_data
  );

endinterface

// ==== hdl/accel_pkg.sv ====
package accel_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================
  localparam int dim       = 4;   // matrix edge and lane count.
  localparam int elem_w    = 8;   // signed int8 operands.
  localparam int acc_w     = 18;  // four int8 products fit without overflow.
  localparam int res_w     = 16;  // one activated result element.
  localparam int ram_depth = 4;   // words per memory.

  // clamp limits for the int8 output range.
  localparam int clamp_max = 127;
  localparam int clamp_min = -128;

  // ==========================================================================
  // types
  // ==========================================================================
  typedef logic [1:0] idx_t;                       // row or column number.

  // element k in bits 8k+7 down to 8k.
  typedef logic [dim*elem_w-1:0] row_t;

  typedef logic signed [acc_w-1:0] acc_t;          // lane dot product.

  typedef logic [res_w-1:0] res_t;

  // element j in bits 16j+15 down to 16j.
  typedef logic [dim*res_w-1:0] out_word_t;

  typedef enum logic [1:0] {
    act_none  = 2'd0,  // low 16 bits of the sum.
    act_relu  = 2'd1,  // negative sums go to zero.
    act_clamp = 2'd2   // saturate to int8.
  } act_mode_t;

endpackage
